/* exe_mem.f */
common/pipe_pkg.sv
common/ex_mem_if.sv
common/sram_if.sv
exe_stage/alu.sv
exe_stage/exe_stage.sv
rtl/mem_stage.sv
rtl/data_sram.sv
rtl/exe_mem_top.sv
tb/tb_exe_mem_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f exe_mem.f \
    --top-module tb_exe_mem_top -o sim_exe_mem

./obj_dir/sim_exe_mem > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation finished without errors"

/* tb/tb_exe_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_exe_mem_top import pipe_pkg::*; ();

    localparam int          NUM_INSTR   = 400;
    localparam int          CLK_PERIOD  = 100;
    localparam int          WATCHDOG_NS = NUM_INSTR * 20 * CLK_PERIOD;
    localparam logic [31:0] SEED        = 32'h6e8a75f8;

    logic        clk = 1'b0;
    logic        resetn = 1'b0;
    logic        in_valid = 1'b0;
    id_to_ex_t   in_bus = '0;
    logic        in_allowin;
    ex_fwd_t     ex_fwd;
    logic        wb_allowin = 1'b0;
    logic        wb_valid;
    logic [31:0] wb_pc;
    logic        wb_rf_we;
    logic [4:0]  wb_rf_waddr;
    logic [31:0] wb_rf_wdata;

    // reference model state
    logic        ex_occ = 1'b0;
    logic        mem_occ = 1'b0;
    id_to_ex_t   ex_inst;
    wb_t         exp_q[$];          // expected writebacks in acceptance order
    logic [31:0] mem_model [0:63];  // shadow of the low 64 sram words
    logic [5:0]  written_q[$];      // word addresses a load may use
    logic [31:0] pc_next = 32'h1c00_0000;
    int          gen_count = 0;
    int          done_count = 0;
    int          cycle = 0;
    int          stall_left = 0;

    exe_mem_top #(.SRAM_AW(10)) u_exe_mem_top (
        .clk         (clk),
        .resetn      (resetn),
        .in_valid    (in_valid),
        .in_bus      (in_bus),
        .in_allowin  (in_allowin),
        .ex_fwd      (ex_fwd),
        .wb_allowin  (wb_allowin),
        .wb_valid    (wb_valid),
        .wb_pc       (wb_pc),
        .wb_rf_we    (wb_rf_we),
        .wb_rf_waddr (wb_rf_waddr),
        .wb_rf_wdata (wb_rf_wdata)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] alu_model(alu_op_t op, logic [31:0] a, logic [31:0] b);
        case (1'b1)
            op[ALU_ADD]:  return a + b;
            op[ALU_SUB]:  return a - b;
            op[ALU_SLT]:  return {31'd0, $signed(a) < $signed(b)};
            op[ALU_SLTU]: return {31'd0, a < b};
            op[ALU_AND]:  return a & b;
            op[ALU_NOR]:  return ~(a | b);
            op[ALU_OR]:   return a | b;
            op[ALU_XOR]:  return a ^ b;
            op[ALU_SLL]:  return a << b[4:0];
            op[ALU_SRL]:  return a >> b[4:0];
            op[ALU_SRA]:  return $signed(a) >>> b[4:0];
            op[ALU_LUI]:  return b;
            default:      return 32'd0;
        endcase
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_with_failure($sformatf("ERROR at %0t: %s expected %b got %b",
                                        $time, name, exp, act));
    endtask

    task automatic check_wb(input wb_t exp, input wb_t act);
        if (act.pc !== exp.pc)
            stop_with_failure($sformatf("ERROR at %0t: wb_pc expected %h got %h",
                                        $time, exp.pc, act.pc));
        else if (act.rf_we !== exp.rf_we)
            stop_with_failure($sformatf("ERROR at %0t: wb_rf_we expected %b got %b",
                                        $time, exp.rf_we, act.rf_we));
        else if (act.rf_waddr !== exp.rf_waddr)
            stop_with_failure($sformatf("ERROR at %0t: wb_rf_waddr expected %0d got %0d",
                                        $time, exp.rf_waddr, act.rf_waddr));
        else if (act.rf_wdata !== exp.rf_wdata)
            stop_with_failure($sformatf("ERROR at %0t: wb_rf_wdata expected %h got %h",
                                        $time, exp.rf_wdata, act.rf_wdata));
    endtask

    // address and result only matter while execute holds something
    task automatic check_fwd(input ex_fwd_t exp, input ex_fwd_t act, input logic occupied);
        if (act.res_from_mem !== exp.res_from_mem)
            stop_with_failure($sformatf("ERROR at %0t: ex_fwd.res_from_mem expected %b got %b",
                                        $time, exp.res_from_mem, act.res_from_mem));
        else if (act.rf_we !== exp.rf_we)
            stop_with_failure($sformatf("ERROR at %0t: ex_fwd.rf_we expected %b got %b",
                                        $time, exp.rf_we, act.rf_we));
        else if (occupied && act.rf_waddr !== exp.rf_waddr)
            stop_with_failure($sformatf("ERROR at %0t: ex_fwd.rf_waddr expected %0d got %0d",
                                        $time, exp.rf_waddr, act.rf_waddr));
        else if (occupied && act.alu_result !== exp.alu_result)
            stop_with_failure($sformatf("ERROR at %0t: ex_fwd.alu_result expected %h got %h",
                                        $time, exp.alu_result, act.alu_result));
    endtask

    // memory effects applied in acceptance order as the sram sees them
    task automatic push_expected(input id_to_ex_t inst);
        logic [31:0] result;
        logic [5:0]  addr;
        wb_t         exp;
        result = alu_model(inst.alu_op, inst.alu_src1, inst.alu_src2);
        addr = result[7:2];
        exp.pc = inst.pc;
        exp.rf_we = inst.rf_we;
        exp.rf_waddr = inst.rf_waddr;
        exp.rf_wdata = result;
        if (inst.mem_we)
            mem_model[addr] = inst.rkd_value;
        else if (inst.res_from_mem)
            exp.rf_wdata = mem_model[addr];
        exp_q.push_back(exp);
    endtask

    task automatic gen_instr(output id_to_ex_t inst);
        int         kind;
        logic [5:0] addr;
        kind = $urandom % 10;
        if (kind >= 8 && written_q.size() == 0) kind = 6;  // nothing to load yet
        inst = '0;
        inst.pc = pc_next;
        pc_next = pc_next + 32'd4;
        inst.rf_waddr = 5'($urandom);
        if (kind < 6) begin
            inst.alu_op = 12'd1 << ($urandom % 12);
            inst.alu_src1 = $urandom;
            inst.alu_src2 = ($urandom % 8 == 0) ? inst.alu_src1 : $urandom;
            inst.rf_we = ($urandom % 8) != 0;
        end else begin
            if (kind < 8) addr = 6'($urandom);
            else addr = written_q[$urandom % written_q.size()];
            inst.alu_op = 12'd1 << ALU_ADD;
            inst.alu_src2 = $urandom;
            inst.alu_src1 = {24'd0, addr, 2'b00} - inst.alu_src2;  // sum lands on addr
            inst.mem_we = kind < 8;
            inst.res_from_mem = kind >= 8;
            inst.rf_we = kind >= 8;
            inst.rkd_value = $urandom;
            if (kind < 8) written_q.push_back(addr);
        end
    endtask

    task automatic check_and_advance_model();
        logic    mem_allow;
        logic    ex_allow;
        ex_fwd_t exp_fwd;
        wb_t     act_wb;
        mem_allow = !mem_occ || wb_allowin;
        ex_allow = !ex_occ || mem_allow;
        check_flag("in_allowin", ex_allow, in_allowin);
        check_flag("wb_valid", mem_occ, wb_valid);
        if (!mem_occ)
            check_flag("wb_rf_we", 1'b0, wb_rf_we);   // qualified by memory stage valid
        exp_fwd.res_from_mem = ex_occ & ex_inst.res_from_mem;
        exp_fwd.rf_we = ex_occ & ex_inst.rf_we;
        exp_fwd.rf_waddr = ex_inst.rf_waddr;
        exp_fwd.alu_result = alu_model(ex_inst.alu_op, ex_inst.alu_src1, ex_inst.alu_src2);
        check_fwd(exp_fwd, ex_fwd, ex_occ);
        if (wb_valid && wb_allowin) begin
            if (exp_q.size() == 0)
                stop_with_failure("writeback seen with no instruction outstanding");
            act_wb.pc = wb_pc;
            act_wb.rf_we = wb_rf_we;
            act_wb.rf_waddr = wb_rf_waddr;
            act_wb.rf_wdata = wb_rf_wdata;
            check_wb(exp_q.pop_front(), act_wb);
            done_count++;
        end
        if (in_valid && in_allowin) push_expected(in_bus);
        if (mem_allow) mem_occ = ex_occ;
        if (ex_allow) begin
            ex_occ = in_valid;
            if (in_valid) ex_inst = in_bus;
        end
    endtask

    task automatic drive_next();
        id_to_ex_t next_inst;
        if (stall_left > 0) begin   // long back-pressure burst
            wb_allowin <= 1'b0;
            stall_left--;
        end else if ($urandom % 48 == 0) begin
            wb_allowin <= 1'b0;
            stall_left = 8 + $urandom % 20;
        end else begin
            wb_allowin <= ($urandom % 10) < 6;
        end
        if (in_valid && !in_allowin) begin
            // hold the pending instruction
        end else if (gen_count < NUM_INSTR && ($urandom % 10) < 7) begin
            gen_instr(next_inst);
            in_bus <= next_inst;
            in_valid <= 1'b1;
            gen_count++;
        end else begin
            in_valid <= 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!resetn) begin
            if (cycle > 0) begin    // registers are unknown before the first reset edge
                check_flag("wb_valid", 1'b0, wb_valid);
                check_flag("ex_fwd.rf_we", 1'b0, ex_fwd.rf_we);
                check_flag("ex_fwd.res_from_mem", 1'b0, ex_fwd.res_from_mem);
            end
            ex_occ = 1'b0;
            mem_occ = 1'b0;
            in_valid <= 1'b0;
            wb_allowin <= 1'b0;
        end else begin
            check_and_advance_model();
            drive_next();
        end
        cycle = cycle + 1;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("watchdog timeout, pipeline did not retire all instructions");
    end

    initial begin
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        wait (done_count == NUM_INSTR);
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0 || ex_occ || mem_occ) begin
            stop_with_failure("instructions still outstanding at the end of the run");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/exe_mem_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_mem_top import pipe_pkg::*; #(
    parameter int SRAM_AW = 10
) (
    input  wire          clk,
    input  wire          resetn,
    input  wire          in_valid,
    input  id_to_ex_t    in_bus,
    output logic         in_allowin,
    output ex_fwd_t      ex_fwd,
    input  wire          wb_allowin,
    output logic         wb_valid,
    output logic [31:0]  wb_pc,
    output logic         wb_rf_we,
    output logic [4:0]   wb_rf_waddr,
    output logic [31:0]  wb_rf_wdata
);

    wb_t wb;

    ex_mem_if u_ex_mem_if ();
    sram_if #(.SRAM_AW(SRAM_AW)) u_sram_if ();

    exe_stage #(
        .SRAM_AW (SRAM_AW)
    ) u_exe_stage (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_bus     (in_bus),
        .in_allowin (in_allowin),
        .ex_mem     (u_ex_mem_if),
        .sram       (u_sram_if),
        .ex_fwd     (ex_fwd)
    );

    mem_stage u_mem_stage (
        .clk        (clk),
        .resetn     (resetn),
        .ex_mem     (u_ex_mem_if),
        .sram_rdata (u_sram_if.rdata),
        .wb_allowin (wb_allowin),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

    data_sram #(
        .SRAM_AW (SRAM_AW)
    ) u_data_sram (
        .clk  (clk),
        .sram (u_sram_if)
    );

    // flatten writeback record onto top ports
    assign wb_pc       = wb.pc;
    assign wb_rf_we    = wb.rf_we;
    assign wb_rf_waddr = wb.rf_waddr;
    assign wb_rf_wdata = wb.rf_wdata;

endmodule

`default_nettype wire

/* rtl/data_sram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_sram #(
    parameter int SRAM_AW = 10
) (
    input  wire       clk,
    sram_if.slave     sram
);

    localparam int DEPTH = 2 ** SRAM_AW;

    logic [31:0] mem [0:DEPTH-1];   // contents unknown until written
    logic [31:0] rdata_q;

    // byte-masked write
    always_ff @(posedge clk) begin
        if (sram.en) begin
            for (int i = 0; i < 4; i++) begin
                if (sram.we[i]) begin
                    mem[sram.addr][i*8 +: 8] <= sram.wdata[i*8 +: 8];
                end
            end
        end
    end

    // read port, output holds between accesses
    always_ff @(posedge clk) begin
        if (sram.en && sram.we == 4'b0000) begin
            rdata_q <= mem[sram.addr];
        end
    end

    assign sram.rdata = rdata_q;

endmodule

`default_nettype wire

/* rtl/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage import pipe_pkg::*; (
    input  wire          clk,
    input  wire          resetn,
    ex_mem_if.sink       ex_mem,
    input  wire  [31:0]  sram_rdata,
    input  wire          wb_allowin,
    output logic         wb_valid,
    output wb_t          wb
);

    logic        mem_valid;
    logic        mem_ready_go;
    logic        mem_allowin;
    logic [31:0] mem_pc;
    logic        mem_res_from_mem;
    logic        mem_rf_we;
    logic [4:0]  mem_rf_waddr;
    logic [31:0] mem_alu_result;

    // load data arrives with the instruction, nothing to wait for
    assign mem_ready_go   = 1'b1;
    assign mem_allowin    = ~mem_valid | (mem_ready_go & wb_allowin);
    assign ex_mem.allowin = mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= ex_mem.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_mem.valid && mem_allowin) begin
            mem_pc           <= ex_mem.pc;
            mem_res_from_mem <= ex_mem.res_from_mem;
            mem_rf_we        <= ex_mem.rf_we;
            mem_rf_waddr     <= ex_mem.rf_waddr;
            mem_alu_result   <= ex_mem.alu_result;
        end
    end

    assign wb_valid    = mem_valid & mem_ready_go;
    assign wb.pc       = mem_pc;
    assign wb.rf_we    = mem_rf_we & mem_valid;
    assign wb.rf_waddr = mem_rf_waddr;
    assign wb.rf_wdata = mem_res_from_mem ? sram_rdata : mem_alu_result;  // load or alu

endmodule

`default_nettype wire

/* exe_stage/exe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_stage import pipe_pkg::*; #(
    parameter int SRAM_AW = 10
) (
    input  wire          clk,
    input  wire          resetn,
    input  wire          in_valid,
    input  id_to_ex_t    in_bus,
    output logic         in_allowin,
    ex_mem_if.source     ex_mem,
    sram_if.master       sram,
    output ex_fwd_t      ex_fwd
);

    logic        ex_valid;
    id_to_ex_t   ex_bus;       // registered instruction
    logic        ex_ready_go;
    logic        ex_xfer;
    logic [31:0] alu_result;

    // no multi-cycle ops here
    assign ex_ready_go = 1'b1;
    assign in_allowin  = ~ex_valid | (ex_ready_go & ex_mem.allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ex_valid <= 1'b0;
        end else if (in_allowin) begin
            ex_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            ex_bus <= in_bus;
        end
    end

    alu u_alu (
        .alu_op     (ex_bus.alu_op),
        .alu_src1   (ex_bus.alu_src1),
        .alu_src2   (ex_bus.alu_src2),
        .alu_result (alu_result)
    );

    // handoff to memory stage
    assign ex_mem.valid        = ex_valid & ex_ready_go;
    assign ex_mem.pc           = ex_bus.pc;
    assign ex_mem.res_from_mem = ex_bus.res_from_mem;
    assign ex_mem.rf_we        = ex_bus.rf_we;
    assign ex_mem.rf_waddr     = ex_bus.rf_waddr;
    assign ex_mem.alu_result   = alu_result;

    assign ex_xfer = ex_mem.valid & ex_mem.allowin;

    // sram request only on the advancing cycle so a stalled load keeps rdata
    assign sram.en    = ex_xfer & (ex_bus.res_from_mem | ex_bus.mem_we);
    assign sram.we    = {4{ex_xfer & ex_bus.mem_we}};   // word stores only
    assign sram.addr  = alu_result[SRAM_AW+1:2];
    assign sram.wdata = ex_bus.rkd_value;

    // forwarding back toward decode
    assign ex_fwd.res_from_mem = ex_bus.res_from_mem & ex_valid;
    assign ex_fwd.rf_we        = ex_bus.rf_we & ex_valid;
    assign ex_fwd.rf_waddr     = ex_bus.rf_waddr;
    assign ex_fwd.alu_result   = alu_result;

endmodule

`default_nettype wire

/* exe_stage/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu import pipe_pkg::*; (
    input  alu_op_t      alu_op,
    input  wire  [31:0]  alu_src1,
    input  wire  [31:0]  alu_src2,
    output logic [31:0]  alu_result
);

    logic        adder_inv;
    logic [31:0] adder_b;
    logic [31:0] adder_sum;
    logic        adder_cout;

    logic [31:0] slt_result;
    logic [31:0] sltu_result;
    logic [31:0] and_result;
    logic [31:0] nor_result;
    logic [31:0] or_result;
    logic [31:0] xor_result;
    logic [31:0] sll_result;
    logic [31:0] srl_result;
    logic [31:0] sra_result;
    logic [31:0] lui_result;
    logic [4:0]  shamt;

    // one adder for add/sub/slt/sltu, subtract is a + ~b + 1
    assign adder_inv = alu_op[ALU_SUB] | alu_op[ALU_SLT] | alu_op[ALU_SLTU];
    assign adder_b   = adder_inv ? ~alu_src2 : alu_src2;
    assign {adder_cout, adder_sum} = {1'b0, alu_src1} + {1'b0, adder_b} + {32'd0, adder_inv};

    // signed less than from operand signs and difference sign
    assign slt_result  = {31'd0, (alu_src1[31] & ~alu_src2[31])
                               | (~(alu_src1[31] ^ alu_src2[31]) & adder_sum[31])};
    assign sltu_result = {31'd0, ~adder_cout};   // borrow out

    assign and_result = alu_src1 & alu_src2;
    assign nor_result = ~(alu_src1 | alu_src2);
    assign or_result  = alu_src1 | alu_src2;
    assign xor_result = alu_src1 ^ alu_src2;

    assign shamt      = alu_src2[4:0];
    assign sll_result = alu_src1 << shamt;
    assign srl_result = alu_src1 >> shamt;
    assign sra_result = $signed(alu_src1) >>> shamt;
    assign lui_result = alu_src2;   // immediate already shifted by decode

    // one-hot and-or select
    assign alu_result = ({32{alu_op[ALU_ADD] | alu_op[ALU_SUB]}} & adder_sum)
                      | ({32{alu_op[ALU_SLT]}}  & slt_result)
                      | ({32{alu_op[ALU_SLTU]}} & sltu_result)
                      | ({32{alu_op[ALU_AND]}}  & and_result)
                      | ({32{alu_op[ALU_NOR]}}  & nor_result)
                      | ({32{alu_op[ALU_OR]}}   & or_result)
                      | ({32{alu_op[ALU_XOR]}}  & xor_result)
                      | ({32{alu_op[ALU_SLL]}}  & sll_result)
                      | ({32{alu_op[ALU_SRL]}}  & srl_result)
                      | ({32{alu_op[ALU_SRA]}}  & sra_result)
                      | ({32{alu_op[ALU_LUI]}}  & lui_result);

endmodule

`default_nettype wire

/* common/sram_if.sv */
`timescale 1ns/10ps
`default_nettype none

// single port data sram, word addressed
interface sram_if #(
    parameter int SRAM_AW = 10
);

    logic               en;
    logic [3:0]         we;     // byte write mask
    logic [SRAM_AW-1:0] addr;
    logic [31:0]        wdata;
    logic [31:0]        rdata;

    modport master (
        output en, we, addr, wdata,
        input  rdata
    );

    modport slave (
        input  en, we, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

/* common/ex_mem_if.sv */
`timescale 1ns/10ps
`default_nettype none

// execute to memory stage handoff
interface ex_mem_if;

    logic        valid;
    logic        allowin;
    logic [31:0] pc;
    logic        res_from_mem;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] alu_result;

    modport source (
        output valid, pc, res_from_mem, rf_we, rf_waddr, alu_result,
        input  allowin
    );

    modport sink (
        input  valid, pc, res_from_mem, rf_we, rf_waddr, alu_result,
        output allowin
    );

endinterface

`default_nettype wire

/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    // one-hot alu operation bit positions
    localparam int unsigned ALU_ADD  = 0;
    localparam int unsigned ALU_SUB  = 1;
    localparam int unsigned ALU_SLT  = 2;
    localparam int unsigned ALU_SLTU = 3;
    localparam int unsigned ALU_AND  = 4;
    localparam int unsigned ALU_NOR  = 5;
    localparam int unsigned ALU_OR   = 6;
    localparam int unsigned ALU_XOR  = 7;
    localparam int unsigned ALU_SLL  = 8;
    localparam int unsigned ALU_SRL  = 9;
    localparam int unsigned ALU_SRA  = 10;
    localparam int unsigned ALU_LUI  = 11;

    typedef logic [11:0] alu_op_t;

    // decoded instruction from decode, 148 bits
    typedef struct packed {
        alu_op_t     alu_op;
        logic        res_from_mem;  // load
        logic [31:0] alu_src1;
        logic [31:0] alu_src2;
        logic        mem_we;        // store
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rkd_value;     // store data
        logic [31:0] pc;
    } id_to_ex_t;

    // forwarding record back to decode, flags already qualified by ex valid
    typedef struct packed {
        logic        res_from_mem;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] alu_result;
    } ex_fwd_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
    } wb_t;

endpackage

`default_nettype wire
